// ==== dv/cache_array_sva.sv ====
// victim queue protocol checks

`timescale 1ns/1ps

module cache_array_sva
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input logic                   clock,
  input logic                   reset,
  input logic [WR_PORTS-1:0]    push,
  input logic [VQ_CNT_BITS-1:0] free_slots,
  input logic [VQ_CNT_BITS-1:0] count,
  input logic [CREDIT_BITS-1:0] credits,
  input logic                   evict_credit,
  input logic                   evict_valid
);

  int unsigned failures = 0;

  // credits as seen from the link side
  int link_credits;

  always_ff @(posedge clock) begin
    if (reset) begin
      link_credits <= EVICT_CREDITS;
    end else begin
      link_credits <= link_credits + int'(evict_credit) - int'(evict_valid);
    end
  end

  a_credit_limit: assert property (@(posedge clock) disable iff (reset)
    credits <= CREDIT_BITS'(EVICT_CREDITS))
  else begin
    $error("credit counter above the granted credits");
    failures++;
  end

  a_valid_needs_credit: assert property (@(posedge clock) disable iff (reset)
    evict_valid |-> (link_credits > 0))
  else begin
    $error("line presented without a credit");
    failures++;
  end

  // the array holds writes off while stalled, so no evictions arrive
  a_stall_blocks_push: assert property (@(posedge clock) disable iff (reset)
    (free_slots < VQ_CNT_BITS'(WR_PORTS)) |-> (push == '0))
  else begin
    $error("push while fewer free slots than write ports");
    failures++;
  end

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    (int'(count) + $countones(push)) <= VQ_DEPTH)
  else begin
    $error("push into a full victim queue");
    failures++;
  end

endmodule

bind victim_queue cache_array_sva u_sva (
  .clock        (clock),
  .reset        (reset),
  .push         (push),
  .free_slots   (free_slots),
  .count        (count),
  .credits      (credits),
  .evict_credit (evict_credit),
  .evict_valid  (evict_valid)
);

// ==== dv/cache_array_tb.sv ====
// cache array testbench

`timescale 1ns/1ps

module cache_array_tb
  import cache_geom_pkg::*, cache_msg_pkg::*;
();

  localparam int WAIT_LIMIT = 200;
  localparam int NUM_DATA   = 28;

  // one table row, eviction expected where line.valid is set
  typedef struct packed {
    rd_req_t  [RD_PORTS-1:0] rd;
    wr_req_t  [WR_PORTS-1:0] wr;
    rd_resp_t [RD_PORTS-1:0] exp;
    evict_t   [WR_PORTS-1:0] ev;
    logic                    stall;
  } row_t;

  logic     clock;
  logic     reset;
  rd_req_t  rd_req [RD_PORTS];
  wr_req_t  wr_req [WR_PORTS];
  rd_resp_t rd_resp [RD_PORTS];
  logic     wr_stall;
  logic     evict_credit;
  logic     evict_valid;
  evict_t   evict_line;

  row_t                 table_q [$];
  evict_t               expected_q [$];
  logic [DATA_BITS-1:0] d [NUM_DATA];
  logic [31:0]          rng_state;
  logic                 credit_on;
  int                   owed;
  int                   phase_evicts;
  int                   mismatches;
  int                   other_errors;

  cache_array_top DUT (
    .clock        (clock),
    .reset        (reset),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .rd_resp      (rd_resp),
    .wr_stall     (wr_stall),
    .evict_credit (evict_credit),
    .evict_valid  (evict_valid),
    .evict_line   (evict_line)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic rd_req_t read_req(input cache_tag_t tag, input cache_idx_t idx);
    rd_req_t r;
    r.en       = 1'b1;
    r.addr.raw = {tag, idx, OFFSET_BITS'(5)};
    return r;
  endfunction

  function automatic wr_req_t write_req(input cache_tag_t tag, input cache_idx_t idx,
                                        input logic [DATA_BITS-1:0] data, input logic dirty);
    wr_req_t w;
    w.en       = 1'b1;
    w.addr.raw = {tag, idx, OFFSET_BITS'(2)};
    w.data     = data;
    w.dirty    = dirty;
    return w;
  endfunction

  function automatic rd_resp_t hit_resp(input logic [DATA_BITS-1:0] data, input cache_way_t way);
    rd_resp_t r;
    r      = '0;
    r.hit  = 1'b1;
    r.data = data;
    r.way  = way;
    return r;
  endfunction

  function automatic rd_resp_t miss_resp(input cache_tag_t tag, input cache_idx_t idx);
    rd_resp_t r;
    r          = '0;
    r.miss     = 1'b1;
    r.miss_idx = idx;
    r.miss_tag = tag;
    return r;
  endfunction

  function automatic evict_t victim_line(input cache_idx_t idx, input cache_tag_t tag,
                                         input logic [DATA_BITS-1:0] data, input logic dirty);
    evict_t e;
    e.idx        = idx;
    e.line.data  = data;
    e.line.tag   = tag;
    e.line.valid = 1'b1;
    e.line.dirty = dirty;
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h exp %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_rd_resp(input int row, input int port, input rd_resp_t got,
                               input rd_resp_t exp);
    string pfx;
    pfx = $sformatf("row %0d rd_resp[%0d]", row, port);
    compare_field({pfx, ".hit"}, got.hit, exp.hit);
    compare_field({pfx, ".miss"}, got.miss, exp.miss);
    if (exp.hit) begin
      compare_field({pfx, ".data"}, got.data, exp.data);
      compare_field({pfx, ".way"}, got.way, exp.way);
    end
    if (exp.miss) begin
      compare_field({pfx, ".miss_idx"}, got.miss_idx, exp.miss_idx);
      compare_field({pfx, ".miss_tag"}, got.miss_tag, exp.miss_tag);
    end
  endtask

  task automatic check_evict(input evict_t got, input evict_t exp);
    compare_field("evict_line.idx", got.idx, exp.idx);
    compare_field("evict_line.line.tag", got.line.tag, exp.line.tag);
    compare_field("evict_line.line.data", got.line.data, exp.line.data);
    compare_field("evict_line.line.valid", got.line.valid, exp.line.valid);
    compare_field("evict_line.line.dirty", got.line.dirty, exp.line.dirty);
  endtask

  task automatic check_stall(input string when, input logic exp);
    compare_field({when, " wr_stall"}, wr_stall, exp);
  endtask

  task automatic add_row(input rd_req_t r0, input rd_req_t r1, input wr_req_t w0,
                         input wr_req_t w1, input rd_resp_t e0, input rd_resp_t e1,
                         input evict_t v0, input evict_t v1, input logic stall);
    row_t r;
    r.rd    = {r1, r0};
    r.wr    = {w1, w0};
    r.exp   = {e1, e0};
    r.ev    = {v1, v0};
    r.stall = stall;
    table_q.push_back(r);
  endtask

  task automatic build_table(output int split);
    rd_req_t  nr;
    wr_req_t  nw;
    rd_resp_t ne;
    evict_t   nv;
    nr = '0;
    nw = '0;
    ne = '0;
    nv = '0;
    // fill and hit on sets 1 and 2
    add_row(nr, nr, write_req(9'h011, 4'd1, d[0], 1'b0), write_req(9'h022, 4'd2, d[1], 1'b1),
            ne, ne, nv, nv, 1'b0);
    add_row(read_req(9'h011, 4'd1), read_req(9'h022, 4'd2), nw, nw,
            hit_resp(d[0], 2'd0), hit_resp(d[1], 2'd0), nv, nv, 1'b0);
    add_row(nr, nr, write_req(9'h033, 4'd1, d[2], 1'b0), write_req(9'h044, 4'd2, d[3], 1'b0),
            ne, ne, nv, nv, 1'b0);
    add_row(read_req(9'h033, 4'd1), read_req(9'h044, 4'd2), nw, nw,
            hit_resp(d[2], 2'd2), hit_resp(d[3], 2'd2), nv, nv, 1'b0);
    // read misses
    add_row(read_req(9'h055, 4'd3), read_req(9'h022, 4'd1), nw, nw,
            miss_resp(9'h055, 4'd3), miss_resp(9'h022, 4'd1), nv, nv, 1'b0);
    // forwarding, one allocating write and one write hit
    add_row(read_req(9'h066, 4'd7), read_req(9'h011, 4'd1),
            write_req(9'h011, 4'd1, d[5], 1'b1), write_req(9'h066, 4'd7, d[4], 1'b0),
            hit_resp(d[4], 2'd0), hit_resp(d[5], 2'd0), nv, nv, 1'b0);
    add_row(read_req(9'h066, 4'd7), read_req(9'h011, 4'd1), nw, nw,
            hit_resp(d[4], 2'd0), hit_resp(d[5], 2'd0), nv, nv, 1'b0);
    // set 5 allocates ways 0, 2, 1, 3
    add_row(read_req(9'h0a0, 4'd5), nr, write_req(9'h0a0, 4'd5, d[6], 1'b0), nw,
            hit_resp(d[6], 2'd0), ne, nv, nv, 1'b0);
    add_row(read_req(9'h0a1, 4'd5), nr, write_req(9'h0a1, 4'd5, d[7], 1'b1), nw,
            hit_resp(d[7], 2'd2), ne, nv, nv, 1'b0);
    add_row(nr, read_req(9'h0a2, 4'd5), nw, write_req(9'h0a2, 4'd5, d[8], 1'b0),
            ne, hit_resp(d[8], 2'd1), nv, nv, 1'b0);
    add_row(nr, read_req(9'h0a3, 4'd5), nw, write_req(9'h0a3, 4'd5, d[9], 1'b1),
            ne, hit_resp(d[9], 2'd3), nv, nv, 1'b0);
    // touching way 0 steers the next allocation to way 2
    add_row(read_req(9'h0a0, 4'd5), nr, nw, nw, hit_resp(d[6], 2'd0), ne, nv, nv, 1'b0);
    add_row(nr, read_req(9'h0a4, 4'd5), write_req(9'h0a4, 4'd5, d[10], 1'b0), nw,
            ne, hit_resp(d[10], 2'd2), victim_line(4'd5, 9'h0a1, d[7], 1'b1), nv, 1'b0);
    add_row(read_req(9'h0a1, 4'd5), read_req(9'h0a4, 4'd5), nw, nw,
            miss_resp(9'h0a1, 4'd5), hit_resp(d[10], 2'd2), nv, nv, 1'b0);
    split = table_q.size();
    // back-pressure on sets 9 and 10, credits held back
    add_row(nr, nr, write_req(9'h1b0, 4'd9, d[11], 1'b1), write_req(9'h1c0, 4'd10, d[12], 1'b0),
            ne, ne, nv, nv, 1'b0);
    add_row(nr, nr, write_req(9'h1b1, 4'd9, d[13], 1'b0), write_req(9'h1c1, 4'd10, d[14], 1'b1),
            ne, ne, nv, nv, 1'b0);
    add_row(nr, nr, write_req(9'h1b2, 4'd9, d[15], 1'b1), write_req(9'h1c2, 4'd10, d[16], 1'b0),
            ne, ne, nv, nv, 1'b0);
    add_row(nr, nr, write_req(9'h1b3, 4'd9, d[17], 1'b0), write_req(9'h1c3, 4'd10, d[18], 1'b1),
            ne, ne, nv, nv, 1'b0);
    add_row(nr, nr, write_req(9'h1b4, 4'd9, d[19], 1'b0), write_req(9'h1c4, 4'd10, d[20], 1'b0),
            ne, ne, victim_line(4'd9, 9'h1b0, d[11], 1'b1),
            victim_line(4'd10, 9'h1c0, d[12], 1'b0), 1'b0);
    add_row(nr, nr, write_req(9'h1b5, 4'd9, d[21], 1'b0), write_req(9'h1c5, 4'd10, d[22], 1'b0),
            ne, ne, victim_line(4'd9, 9'h1b1, d[13], 1'b0),
            victim_line(4'd10, 9'h1c1, d[14], 1'b1), 1'b0);
    add_row(nr, nr, write_req(9'h1b6, 4'd9, d[23], 1'b0), write_req(9'h1c6, 4'd10, d[23], 1'b1),
            ne, ne, nv, nv, 1'b1);
    add_row(nr, nr, write_req(9'h1b7, 4'd9, d[24], 1'b0), write_req(9'h1c7, 4'd10, d[25], 1'b0),
            ne, ne, victim_line(4'd9, 9'h1b2, d[15], 1'b1),
            victim_line(4'd10, 9'h1c2, d[16], 1'b0), 1'b0);
    add_row(read_req(9'h1b8, 4'd9), read_req(9'h1c5, 4'd10),
            write_req(9'h1b8, 4'd9, d[26], 1'b1), write_req(9'h1c8, 4'd10, d[27], 1'b1),
            miss_resp(9'h1b8, 4'd9), hit_resp(d[22], 2'd2), nv, nv, 1'b1);
    add_row(read_req(9'h1b6, 4'd9), read_req(9'h1c8, 4'd10), nw, nw,
            miss_resp(9'h1b6, 4'd9), miss_resp(9'h1c8, 4'd10), nv, nv, 1'b1);
    add_row(read_req(9'h1b7, 4'd9), read_req(9'h1c4, 4'd10), nw, nw,
            hit_resp(d[24], 2'd1), hit_resp(d[20], 2'd0), nv, nv, 1'b1);
  endtask

  task automatic apply_rows(input int first, input int last);
    for (int n = first; n <= last; n++) begin
      @(posedge clock);
      for (int p = 0; p < RD_PORTS; p++) begin
        rd_req[p] <= table_q[n].rd[p];
      end
      for (int p = 0; p < WR_PORTS; p++) begin
        wr_req[p] <= table_q[n].wr[p];
        if (table_q[n].ev[p].line.valid) begin
          expected_q.push_back(table_q[n].ev[p]);
        end
      end
      @(negedge clock);
      check_stall($sformatf("row %0d", n), table_q[n].stall);
      for (int p = 0; p < RD_PORTS; p++) begin
        check_rd_resp(n, p, rd_resp[p], table_q[n].exp[p]);
      end
    end
    @(posedge clock);
    for (int p = 0; p < RD_PORTS; p++) begin
      rd_req[p] <= '0;
    end
    for (int p = 0; p < WR_PORTS; p++) begin
      wr_req[p] <= '0;
    end
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while ((expected_q.size() != 0 || owed != 0) && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (expected_q.size() != 0 || owed != 0) begin
      $display("timed out waiting for evicted lines to drain and credits to return");
      other_errors++;
    end
    // returned credit lands one edge later
    repeat (2) @(posedge clock);
  endtask

  task automatic wait_stall_clear();
    int cycles;
    cycles = 0;
    while (wr_stall !== 1'b0 && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (wr_stall !== 1'b0) begin
      $display("timed out waiting for the write stall to clear");
      other_errors++;
    end
  endtask

  // eviction link monitor
  always @(negedge clock) begin
    if (!reset && evict_valid) begin
      owed++;
      phase_evicts++;
      if (expected_q.size() == 0) begin
        $display("a line was presented on the eviction link that no write evicted");
        other_errors++;
      end else begin
        check_evict(evict_line, expected_q.pop_front());
      end
    end
  end

  // next level returns one credit per consumed line while credit_on
  always @(posedge clock) begin
    if (reset) begin
      evict_credit <= 1'b0;
    end else if (credit_on && owed > 0) begin
      evict_credit <= 1'b1;
      owed--;
    end else begin
      evict_credit <= 1'b0;
    end
  end

  initial begin
    int split;
    int sva_failures;
    reset        = 1'b1;
    evict_credit = 1'b0;
    credit_on    = 1'b1;
    owed         = 0;
    phase_evicts = 0;
    mismatches   = 0;
    other_errors = 0;
    for (int p = 0; p < RD_PORTS; p++) begin
      rd_req[p] = '0;
    end
    for (int p = 0; p < WR_PORTS; p++) begin
      wr_req[p] = '0;
    end
    rng_state = 32'h7e4a_a7b1;
    for (int i = 0; i < NUM_DATA; i++) begin
      d[i] = {next_rand(), next_rand()};
    end
    build_table(split);

    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_stall("after reset", 1'b0);
    compare_field("evict_valid after reset", evict_valid, 1'b0);

    apply_rows(0, split - 1);
    wait_for_drain();

    credit_on    = 1'b0;
    phase_evicts = 0;
    apply_rows(split, table_q.size() - 1);
    if (phase_evicts != EVICT_CREDITS) begin
      $display("with credits held back %0d lines left the queue instead of %0d",
               phase_evicts, EVICT_CREDITS);
      other_errors++;
    end
    credit_on = 1'b1;
    wait_for_drain();
    wait_stall_clear();
    if (phase_evicts != 6) begin
      $display("back-pressure phase drained %0d lines instead of 6", phase_evicts);
      other_errors++;
    end

    sva_failures = DUT.u_vq.u_sva.failures;
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             mismatches, other_errors, sva_failures);
    if (mismatches == 0 && other_errors == 0 && sva_failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/cache_geom_pkg.sv
rtl/cache_msg_pkg.sv
rtl/tag_match.sv
rtl/plru_tree.sv
rtl/cache_array.sv
rtl/victim_queue.sv
rtl/cache_array_top.sv
dv/cache_array_sva.sv
dv/cache_array_tb.sv

// ==== rtl/cache_array.sv ====
// set-associative line array with pseudo-LRU

`timescale 1ns/1ps

module cache_array
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  rd_req_t                rd_req [RD_PORTS],
  input  wr_req_t                wr_req [WR_PORTS],
  output rd_resp_t               rd_resp [RD_PORTS],
  input  logic [VQ_CNT_BITS-1:0] free_slots,
  output logic                   wr_stall,
  output logic [WR_PORTS-1:0]    evict_push,
  output evict_t                 evict_data [WR_PORTS]
);

  // line payload, qualified by the reset-cleared valid bits
  cache_set_t          lines [NUM_SETS];
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  plru_bits_t          plru [NUM_SETS];
  plru_bits_t          plru_next [NUM_SETS];

  cache_set_t          rd_set [RD_PORTS];
  logic [RD_PORTS-1:0] rd_match;
  cache_way_t          rd_match_way [RD_PORTS];

  cache_set_t          wr_set [WR_PORTS];
  logic [WR_PORTS-1:0] wr_match;
  logic [WR_PORTS-1:0] wr_go;
  cache_way_t          wr_match_way [WR_PORTS];
  cache_way_t          wr_way [WR_PORTS];

  // tree chain, write ports then read ports
  cache_idx_t            tr_idx [PLRU_PORTS];
  logic [PLRU_PORTS-1:0] tr_act;
  logic [PLRU_PORTS-1:0] tr_touch;
  logic [PLRU_PORTS-1:0] tr_alloc;
  cache_way_t            tr_touch_way [PLRU_PORTS];
  cache_way_t            tr_alloc_way [PLRU_PORTS];
  plru_bits_t            tr_in [PLRU_PORTS];
  plru_bits_t            tr_out [PLRU_PORTS];

  function automatic cache_set_t set_view(input cache_idx_t idx);
    cache_set_t view;
    view = lines[idx];
    for (int w = 0; w < NUM_WAYS; w++) begin
      view[w].valid = valid_q[idx][w];
    end
    return view;
  endfunction

  for (genvar i = 0; i < RD_PORTS; i++) begin : g_rd
    always_comb rd_set[i] = set_view(rd_req[i].addr.f.idx);

    tag_match u_match (
      .set_lines (rd_set[i]),
      .tag       (rd_req[i].addr.f.tag),
      .hit       (rd_match[i]),
      .way       (rd_match_way[i])
    );
  end

  for (genvar j = 0; j < WR_PORTS; j++) begin : g_wr
    always_comb wr_set[j] = set_view(wr_req[j].addr.f.idx);

    tag_match u_match (
      .set_lines (wr_set[j]),
      .tag       (wr_req[j].addr.f.tag),
      .hit       (wr_match[j]),
      .way       (wr_match_way[j])
    );
  end

  for (genvar k = 0; k < PLRU_PORTS; k++) begin : g_plru
    // pick up the latest earlier update to the same set
    always_comb begin
      tr_in[k] = plru[tr_idx[k]];
      for (int m = 0; m < k; m++) begin
        if (tr_act[m] && (tr_idx[m] == tr_idx[k])) begin
          tr_in[k] = tr_out[m];
        end
      end
    end

    plru_tree u_tree (
      .tree_in   (tr_in[k]),
      .touch_en  (tr_touch[k]),
      .touch_way (tr_touch_way[k]),
      .alloc_en  (tr_alloc[k]),
      .tree_out  (tr_out[k]),
      .alloc_way (tr_alloc_way[k])
    );
  end

  assign wr_stall = free_slots < VQ_CNT_BITS'(WR_PORTS);

  always_comb begin
    for (int j = 0; j < WR_PORTS; j++) begin
      wr_go[j]        = wr_req[j].en & ~wr_stall;
      tr_idx[j]       = wr_req[j].addr.f.idx;
      tr_act[j]       = wr_go[j];
      tr_touch[j]     = wr_go[j] & wr_match[j];
      tr_alloc[j]     = wr_go[j] & ~wr_match[j];
      tr_touch_way[j] = wr_match_way[j];
      wr_way[j]       = wr_match[j] ? wr_match_way[j] : tr_alloc_way[j];

      // allocating over a valid line evicts it
      evict_push[j]      = tr_alloc[j] & wr_set[j][wr_way[j]].valid;
      evict_data[j].idx  = wr_req[j].addr.f.idx;
      evict_data[j].line = wr_set[j][wr_way[j]];
    end
    for (int i = 0; i < RD_PORTS; i++) begin
      tr_idx[WR_PORTS+i]       = rd_req[i].addr.f.idx;
      tr_act[WR_PORTS+i]       = rd_req[i].en & rd_match[i];
      tr_touch[WR_PORTS+i]     = rd_req[i].en & rd_match[i];
      tr_alloc[WR_PORTS+i]     = 1'b0;
      tr_touch_way[WR_PORTS+i] = rd_match_way[i];
    end
  end

  always_comb begin
    logic fwd;
    for (int i = 0; i < RD_PORTS; i++) begin
      fwd             = 1'b0;
      rd_resp[i]      = '0;
      rd_resp[i].data = rd_set[i][rd_match_way[i]].data;
      rd_resp[i].way  = rd_match_way[i];
      // same-cycle write to this line, last port wins
      for (int j = 0; j < WR_PORTS; j++) begin
        if (wr_go[j] && (wr_req[j].addr.f.idx == rd_req[i].addr.f.idx) &&
            (wr_req[j].addr.f.tag == rd_req[i].addr.f.tag)) begin
          fwd             = 1'b1;
          rd_resp[i].data = wr_req[j].data;
          rd_resp[i].way  = wr_way[j];
        end
      end
      rd_resp[i].hit      = rd_req[i].en & (fwd | rd_match[i]);
      rd_resp[i].miss     = rd_req[i].en & ~rd_resp[i].hit;
      rd_resp[i].miss_idx = rd_req[i].addr.f.idx;
      rd_resp[i].miss_tag = rd_req[i].addr.f.tag;
      if (!rd_resp[i].hit) begin
        rd_resp[i].data = '0;
        rd_resp[i].way  = '0;
      end
    end
  end

  // reads land after writes
  always_comb begin
    plru_next = plru;
    for (int k = 0; k < PLRU_PORTS; k++) begin
      if (tr_act[k]) begin
        plru_next[tr_idx[k]] = tr_out[k];
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int j = 0; j < WR_PORTS; j++) begin
      if (wr_go[j]) begin
        lines[wr_req[j].addr.f.idx][wr_way[j]] <= '{data:  wr_req[j].data,
                                                    tag:   wr_req[j].addr.f.tag,
                                                    valid: 1'b1,
                                                    dirty: wr_req[j].dirty};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        plru[s]    <= '0;
      end
    end else begin
      for (int j = 0; j < WR_PORTS; j++) begin
        if (wr_go[j]) begin
          valid_q[wr_req[j].addr.f.idx][wr_way[j]] <= 1'b1;
        end
      end
      plru <= plru_next;
    end
  end

endmodule

// ==== rtl/cache_array_top.sv ====
// cache array with victim queue

`timescale 1ns/1ps

module cache_array_top
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  rd_req_t  rd_req [RD_PORTS],
  input  wr_req_t  wr_req [WR_PORTS],
  output rd_resp_t rd_resp [RD_PORTS],
  output logic     wr_stall,
  input  logic     evict_credit,
  output logic     evict_valid,
  output evict_t   evict_line
);

  logic [VQ_CNT_BITS-1:0] free_slots;
  logic [WR_PORTS-1:0]    evict_push;
  evict_t                 evict_data [WR_PORTS];

  cache_array u_array (
    .clock      (clock),
    .reset      (reset),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .rd_resp    (rd_resp),
    .free_slots (free_slots),
    .wr_stall   (wr_stall),
    .evict_push (evict_push),
    .evict_data (evict_data)
  );

  victim_queue u_vq (
    .clock        (clock),
    .reset        (reset),
    .push         (evict_push),
    .push_data    (evict_data),
    .free_slots   (free_slots),
    .evict_credit (evict_credit),
    .evict_valid  (evict_valid),
    .evict_line   (evict_line)
  );

endmodule

// ==== rtl/cache_geom_pkg.sv ====
// cache geometry and address layout

package cache_geom_pkg;

  // array shape
  localparam int NUM_SETS = 16;
  localparam int NUM_WAYS = 4;

  // address fields, tag above index above offset
  localparam int SET_BITS    = $clog2(NUM_SETS);
  localparam int TAG_BITS    = 9;
  localparam int OFFSET_BITS = 3;
  localparam int ADDR_BITS   = TAG_BITS + SET_BITS + OFFSET_BITS;

  // way numbering and tree pseudo-LRU
  localparam int WAY_BITS  = $clog2(NUM_WAYS);
  localparam int PLRU_BITS = NUM_WAYS - 1;

  // port counts
  localparam int RD_PORTS = 2;
  localparam int WR_PORTS = 2;

  // one tree update per port, writes first
  localparam int PLRU_PORTS = WR_PORTS + RD_PORTS;

  typedef logic [TAG_BITS-1:0]    cache_tag_t;
  typedef logic [SET_BITS-1:0]    cache_idx_t;
  typedef logic [WAY_BITS-1:0]    cache_way_t;
  typedef logic [PLRU_BITS-1:0]   plru_bits_t;

  typedef struct packed {
    cache_tag_t             tag;
    cache_idx_t             idx;
    logic [OFFSET_BITS-1:0] offset;
  } cache_addr_t;

  // raw word from the requester, field view inside the array
  typedef union packed {
    logic [ADDR_BITS-1:0] raw;
    cache_addr_t          f;
  } cache_addr_u;

endpackage

// ==== rtl/cache_msg_pkg.sv ====
// cache request, response and eviction types

package cache_msg_pkg;

  import cache_geom_pkg::*;

  localparam int DATA_BITS = 64;

  // victim queue sizing
  localparam int VQ_DEPTH    = 4;
  localparam int VQ_PTR_BITS = $clog2(VQ_DEPTH);
  localparam int VQ_CNT_BITS = $clog2(VQ_DEPTH + 1);

  // credits granted by the next level after reset
  localparam int EVICT_CREDITS = 2;
  localparam int CREDIT_BITS   = $clog2(EVICT_CREDITS + 1);

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    cache_tag_t           tag;
    logic                 valid;
    logic                 dirty;
  } cache_line_t;

  // all ways of one set
  typedef cache_line_t [NUM_WAYS-1:0] cache_set_t;

  typedef struct packed {
    logic        en;
    cache_addr_u addr;
  } rd_req_t;

  typedef struct packed {
    logic                 en;
    cache_addr_u          addr;
    logic [DATA_BITS-1:0] data;
    logic                 dirty;
  } wr_req_t;

  typedef struct packed {
    logic                 hit;
    logic [DATA_BITS-1:0] data;
    cache_way_t           way;
    logic                 miss;
    cache_idx_t           miss_idx;
    cache_tag_t           miss_tag;
  } rd_resp_t;

  typedef struct packed {
    cache_idx_t  idx;
    cache_line_t line;
  } evict_t;

endpackage

// ==== rtl/plru_tree.sv ====
// tree pseudo-LRU update for one set

`timescale 1ns/1ps

module plru_tree
  import cache_geom_pkg::*;
(
  input  logic [PLRU_BITS-1:0] tree_in,
  input  logic                 touch_en,
  input  logic [WAY_BITS-1:0]  touch_way,
  input  logic                 alloc_en,
  output logic [PLRU_BITS-1:0] tree_out,
  output logic [WAY_BITS-1:0]  alloc_way
);

  // node 0 is the root, children of node n sit at 2n+1 and 2n+2
  logic [PLRU_BITS-1:0] tree;
  logic [WAY_BITS-1:0]  walk_way;
  int                   node;
  logic                 upper;

  always_comb begin
    tree     = tree_in;
    walk_way = '0;
    node     = 0;
    upper    = 1'b0;

    // allocate walk, flip each node then follow it
    if (alloc_en) begin
      for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
        tree[node] = ~tree[node];
        upper      = ~tree[node];
        walk_way   = {walk_way[WAY_BITS-2:0], upper};
        node       = 2 * node + 1 + int'(upper);
      end
    end

    // touch, make every node on the path point away
    if (touch_en) begin
      node = 0;
      for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
        upper      = touch_way[WAY_BITS-1-lvl];
        tree[node] = ~upper;
        node       = 2 * node + 1 + int'(upper);
      end
    end
  end

  assign tree_out  = tree;
  assign alloc_way = walk_way;

endmodule

// ==== rtl/tag_match.sv ====
// set tag compare and way encoder

`timescale 1ns/1ps

module tag_match
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  cache_set_t           set_lines,
  input  logic [TAG_BITS-1:0]  tag,
  output logic                 hit,
  output logic [WAY_BITS-1:0]  way
);

  logic [NUM_WAYS-1:0] way_hits;

  // only valid lines can match
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hits[w] = set_lines[w].valid && (set_lines[w].tag == tag);
    end
  end

  assign hit = |way_hits;

  // lowest matching way wins
  always_comb begin
    way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hits[w]) begin
        way = WAY_BITS'(w);
      end
    end
  end

endmodule

// ==== rtl/victim_queue.sv ====
// victim line FIFO with credit drain

`timescale 1ns/1ps

module victim_queue
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic [WR_PORTS-1:0]    push,
  input  evict_t                 push_data [WR_PORTS],
  output logic [VQ_CNT_BITS-1:0] free_slots,
  input  logic                   evict_credit,
  output logic                   evict_valid,
  output evict_t                 evict_line
);

  evict_t                 mem [VQ_DEPTH];
  logic [VQ_PTR_BITS-1:0] wr_ptr;
  logic [VQ_PTR_BITS-1:0] rd_ptr;
  logic [VQ_CNT_BITS-1:0] count;
  logic [CREDIT_BITS-1:0] credits;

  logic [VQ_CNT_BITS-1:0] n_push;
  logic [VQ_PTR_BITS-1:0] push_slot [WR_PORTS];
  logic                   pop;

  // port 0 lands first, port 1 right behind it
  always_comb begin
    n_push = '0;
    for (int j = 0; j < WR_PORTS; j++) begin
      push_slot[j] = wr_ptr + VQ_PTR_BITS'(n_push);
      n_push       = n_push + VQ_CNT_BITS'(push[j]);
    end
  end

  // one line per credit, one per cycle
  assign pop         = (credits != '0) && (count != '0);
  assign evict_valid = pop;
  assign evict_line  = mem[rd_ptr];
  assign free_slots  = VQ_CNT_BITS'(VQ_DEPTH) - count;

  always_ff @(posedge clock) begin
    for (int j = 0; j < WR_PORTS; j++) begin
      if (push[j]) begin
        mem[push_slot[j]] <= push_data[j];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CREDIT_BITS'(EVICT_CREDITS);
    end else begin
      wr_ptr  <= wr_ptr + VQ_PTR_BITS'(n_push);
      rd_ptr  <= rd_ptr + VQ_PTR_BITS'(pop);
      count   <= count + n_push - VQ_CNT_BITS'(pop);
      credits <= credits + CREDIT_BITS'(evict_credit) - CREDIT_BITS'(pop);
    end
  end

endmodule
